// File: hdl/umode_params.svh
/* constants for the privilege-mode checker: CSR field positions,
   instruction encodings, exception causes and report channel sizes */
`ifndef UMODE_PARAMS_SVH
`define UMODE_PARAMS_SVH

// misa extension bits
`define UMODE_MISA_U_POS 20
`define UMODE_MISA_S_POS 18
`define UMODE_MISA_N_POS 13

// mstatus fields
`define UMODE_MPP_POS  11
`define UMODE_MPP_W    2
`define UMODE_MPRV_POS 17
`define UMODE_TW_POS   21

// full instruction words
`define UMODE_MRET_INSN     32'h3020_0073
`define UMODE_WFI_INSN      32'h1050_0073
`define UMODE_ECALL_INSN    32'h0000_0073
`define UMODE_SYSTEM_OPCODE 7'b111_0011

`define UMODE_EXC_ILLEGAL 6'd2
`define UMODE_EXC_ECALL_U 6'd8

// report path sizing
`define UMODE_REPORT_DEPTH   4
`define UMODE_REPORT_CREDITS 2
`define UMODE_SEQ_W          16

`endif

// File: hdl/umode_pkg.sv
/* shared types of the privilege-mode checker: trace record, decoded
   record, violation mask and the report sent to the debug sink */
`include "umode_params.svh"

package umode_pkg;

  typedef logic [1:0]              priv_mode_t;
  typedef logic [31:0]             csr_word_t;
  typedef logic [31:0]             insn_t;
  typedef logic [5:0]              exc_cause_t;
  typedef logic [`UMODE_SEQ_W-1:0] seq_t;
  typedef logic [11:0]             rule_mask_t;

  localparam priv_mode_t MODE_U = 2'b00;
  localparam priv_mode_t MODE_M = 2'b11;

  // bit positions in rule_mask_t
  localparam int RULE_MISA_BITS   = 0;
  localparam int RULE_MODE_LEGAL  = 1;
  localparam int RULE_RESET_MODE  = 2;
  localparam int RULE_MSCRATCH_U  = 3;
  localparam int RULE_MPP_LEGAL   = 4;
  localparam int RULE_TRAP_TO_M   = 5;
  localparam int RULE_DMODE_M     = 6;
  localparam int RULE_UMODE_MPRV  = 7;
  localparam int RULE_WFI_TW      = 8;
  localparam int RULE_ECALL_U     = 9;
  localparam int RULE_MRET_TARGET = 10;
  localparam int RULE_CSR_PRIV    = 11;

  // one retirement from the core trace
  typedef struct packed {
    logic       valid;
    priv_mode_t mode;
    logic       dbg_mode;
    insn_t      insn;
    logic       trap;
    exc_cause_t exc_cause;
    logic       intr;
    csr_word_t  mstatus_rdata;
    csr_word_t  mstatus_wdata;
    csr_word_t  mstatus_wmask;
    csr_word_t  misa_rdata;
    csr_word_t  mscratch_wmask;
  } retire_rec_t;

  typedef struct packed {
    retire_rec_t rec;
    logic        is_mret;
    logic        is_wfi;
    logic        is_ecall;
    logic        is_csr;
    logic        csr_above_user;
  } decoded_t;

  typedef struct packed {
    seq_t       seq;
    rule_mask_t mask;
    priv_mode_t mode;
  } report_t;

endpackage

// File: hdl/retire_decoder.sv
/* stage 1 of the checker: registers the retirement record and
   classifies its instruction for the rule stages */
`timescale 1ns/1ps
`include "umode_params.svh"

module retire_decoder (
  input  logic                   clk_i,
  input  logic                   arst_n,
  input  umode_pkg::retire_rec_t retire,
  output umode_pkg::decoded_t    dec
);

  umode_pkg::decoded_t dec_d;
  umode_pkg::decoded_t dec_q;
  logic                valid_q;
  logic [2:0]          funct3;

  assign funct3 = retire.insn[14:12];

  always_comb begin
    dec_d          = '0;
    dec_d.rec      = retire;
    dec_d.is_mret  = (retire.insn == `UMODE_MRET_INSN);
    dec_d.is_wfi   = (retire.insn == `UMODE_WFI_INSN);
    dec_d.is_ecall = (retire.insn == `UMODE_ECALL_INSN);
    // csrrw/s/c and their immediate forms
    dec_d.is_csr   = (retire.insn[6:0] == `UMODE_SYSTEM_OPCODE) &&
                     (funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});
    // csr address bits 9:8 give the lowest privilege allowed
    dec_d.csr_above_user = dec_d.is_csr && (retire.insn[29:28] != 2'b00);
  end

  always_ff @(posedge clk_i) begin
    dec_q <= dec_d;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= retire.valid;
    end
  end

  always_comb begin
    dec           = dec_q;
    dec.rec.valid = valid_q;
  end

endmodule

// File: hdl/mode_tracker.sv
/* stage 2 sequence checks: keeps state across valid retirements and
   flags the rules that span more than one record */
`timescale 1ns/1ps
`include "umode_params.svh"

module mode_tracker (
  input  logic                  clk_i,
  input  logic                  arst_n,
  input  umode_pkg::decoded_t   dec,
  output umode_pkg::rule_mask_t seq_mask,
  output umode_pkg::seq_t       seq_num
);

  logic                  first_q;
  logic                  prev_trap_q;
  logic                  mret_pend_q;
  umode_pkg::priv_mode_t mret_mpp_q;
  umode_pkg::seq_t       seq_cnt_q;
  umode_pkg::rule_mask_t mask_d;
  logic                  not_m;

  assign not_m = (dec.rec.mode != umode_pkg::MODE_M);

  always_comb begin
    mask_d = '0;
    if (dec.rec.valid) begin
      mask_d[umode_pkg::RULE_RESET_MODE]  = first_q && not_m;
      mask_d[umode_pkg::RULE_TRAP_TO_M]   = prev_trap_q && not_m;
      // an interrupt may preempt the return target
      mask_d[umode_pkg::RULE_MRET_TARGET] = mret_pend_q && !dec.rec.intr &&
                                            (dec.rec.mode != mret_mpp_q);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      first_q     <= 1'b1;
      prev_trap_q <= 1'b0;
      mret_pend_q <= 1'b0;
      seq_cnt_q   <= '0;
      seq_mask    <= '0;
    end else begin
      seq_mask <= mask_d;
      if (dec.rec.valid) begin
        first_q     <= 1'b0;
        prev_trap_q <= dec.rec.trap;
        mret_pend_q <= dec.is_mret && !dec.rec.trap && !dec.rec.dbg_mode &&
                       (dec.rec.mode == umode_pkg::MODE_M);
        seq_cnt_q   <= seq_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    seq_num <= seq_cnt_q;
    if (dec.rec.valid) begin
      mret_mpp_q <= dec.rec.mstatus_rdata[`UMODE_MPP_POS +: `UMODE_MPP_W];
    end
  end

  a_no_mask_after_gap: assert property (
    @(posedge clk_i) disable iff (!arst_n)
    !dec.rec.valid |=> (seq_mask == '0)
  );

endmodule

// File: hdl/rule_checker.sv
/* stage 2 record checks: applies the rules that need only the current
   retirement and carries valid and mode alongside the masks */
`timescale 1ns/1ps
`include "umode_params.svh"

module rule_checker (
  input  logic                  clk_i,
  input  logic                  arst_n,
  input  umode_pkg::decoded_t   dec,
  output umode_pkg::rule_mask_t rec_mask,
  output logic                  stage2_valid,
  output umode_pkg::priv_mode_t stage2_mode
);

  umode_pkg::csr_word_t  mstatus_post;
  umode_pkg::priv_mode_t post_mpp;
  umode_pkg::rule_mask_t mask_d;
  logic                  in_user;
  logic                  is_illegal;
  logic                  tw;

  // mstatus after this retirement
  assign mstatus_post = (dec.rec.mstatus_wdata & dec.rec.mstatus_wmask) |
                        (dec.rec.mstatus_rdata & ~dec.rec.mstatus_wmask);
  assign post_mpp     = mstatus_post[`UMODE_MPP_POS +: `UMODE_MPP_W];
  assign in_user      = (dec.rec.mode == umode_pkg::MODE_U);
  assign is_illegal   = dec.rec.trap && (dec.rec.exc_cause == `UMODE_EXC_ILLEGAL);
  assign tw           = dec.rec.mstatus_rdata[`UMODE_TW_POS];

  always_comb begin
    mask_d = '0;
    if (dec.rec.valid) begin
      mask_d[umode_pkg::RULE_MISA_BITS]  = !(dec.rec.misa_rdata[`UMODE_MISA_U_POS] &&
                                            !dec.rec.misa_rdata[`UMODE_MISA_S_POS] &&
                                            !dec.rec.misa_rdata[`UMODE_MISA_N_POS]);
      mask_d[umode_pkg::RULE_MODE_LEGAL] = !(dec.rec.mode inside
                                            {umode_pkg::MODE_U, umode_pkg::MODE_M});
      mask_d[umode_pkg::RULE_MSCRATCH_U] = in_user && (dec.rec.mscratch_wmask != '0);
      mask_d[umode_pkg::RULE_MPP_LEGAL]  = !(post_mpp inside
                                            {umode_pkg::MODE_U, umode_pkg::MODE_M});
      mask_d[umode_pkg::RULE_DMODE_M]    = dec.rec.dbg_mode &&
                                           (dec.rec.mode != umode_pkg::MODE_M);
      mask_d[umode_pkg::RULE_UMODE_MPRV] = in_user &&
                                           dec.rec.mstatus_rdata[`UMODE_MPRV_POS];
      // wfi in user traps illegal exactly when tw is set
      mask_d[umode_pkg::RULE_WFI_TW]     = dec.is_wfi && in_user && (is_illegal != tw);
      mask_d[umode_pkg::RULE_ECALL_U]    = dec.is_ecall && in_user &&
                                           !(dec.rec.trap &&
                                             (dec.rec.exc_cause == `UMODE_EXC_ECALL_U));
      mask_d[umode_pkg::RULE_CSR_PRIV]   = dec.is_csr && in_user &&
                                           dec.csr_above_user && !is_illegal;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      rec_mask     <= '0;
      stage2_valid <= 1'b0;
    end else begin
      rec_mask     <= mask_d;
      stage2_valid <= dec.rec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    stage2_mode <= dec.rec.mode;
  end

  a_mask_needs_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n)
    !stage2_valid |-> (rec_mask == '0)
  );

endmodule

// File: hdl/report_fifo.sv
/* small circular queue holding violation reports until the output
   channel has a credit; head entry is visible on pop_data */
`timescale 1ns/1ps
`include "umode_params.svh"

module report_fifo #(
  parameter int DEPTH = `UMODE_REPORT_DEPTH
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               push,
  input  umode_pkg::report_t push_data,
  input  logic               pop,
  output umode_pkg::report_t pop_data,
  output logic               full,
  output logic               empty
);

  localparam int PTR_W = $clog2(DEPTH);

  umode_pkg::report_t mem [DEPTH];
  // extra msb tells full from empty
  logic [PTR_W:0]     wr_ptr_q;
  logic [PTR_W:0]     rd_ptr_q;

  assign empty    = (wr_ptr_q == rd_ptr_q);
  assign full     = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                    (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign pop_data = mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= push_data;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!arst_n) !(push && full)
  );

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!arst_n) !(pop && empty)
  );

endmodule

// File: hdl/report_ctrl.sv
/* merges the stage 2 masks into reports, queues or drops them, and
   sends queued reports to the sink as credits allow */
`timescale 1ns/1ps
`include "umode_params.svh"

module report_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n,
  input  logic                  stage2_valid,
  input  umode_pkg::priv_mode_t stage2_mode,
  input  umode_pkg::rule_mask_t seq_mask,
  input  umode_pkg::rule_mask_t rec_mask,
  input  umode_pkg::seq_t       seq_num,
  input  logic                  credit_return,
  output umode_pkg::report_t    report,
  output logic                  report_valid,
  output umode_pkg::seq_t       drop_count
);

  localparam int CREDIT_W = $clog2(`UMODE_REPORT_CREDITS + 1);

  umode_pkg::rule_mask_t merged;
  umode_pkg::report_t    push_data;
  umode_pkg::report_t    pop_data;
  logic                  want_push;
  logic                  push;
  logic                  send;
  logic                  full;
  logic                  empty;
  logic [CREDIT_W-1:0]   credits_q;

  assign merged    = seq_mask | rec_mask;
  assign want_push = stage2_valid && (merged != '0);
  assign push      = want_push && !full;
  assign send      = (credits_q != '0) && !empty;

  always_comb begin
    push_data.seq  = seq_num;
    push_data.mask = merged;
    push_data.mode = stage2_mode;
  end

  report_fifo #(
    .DEPTH(`UMODE_REPORT_DEPTH)
  ) u_fifo (
    .clk_i    (clk_i),
    .arst_n   (arst_n),
    .push     (push),
    .push_data(push_data),
    .pop      (send),
    .pop_data (pop_data),
    .full     (full),
    .empty    (empty)
  );

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      credits_q    <= CREDIT_W'(`UMODE_REPORT_CREDITS);
      report_valid <= 1'b0;
      drop_count   <= '0;
    end else begin
      report_valid <= send;
      // a return and a spend in the same cycle cancel out
      if (credit_return && !send) begin
        credits_q <= credits_q + 1'b1;
      end else if (send && !credit_return) begin
        credits_q <= credits_q - 1'b1;
      end
      if (want_push && full && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      report <= pop_data;
    end
  end

  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!arst_n)
    credits_q <= CREDIT_W'(`UMODE_REPORT_CREDITS)
  );

endmodule

// File: hdl/umode_checker_top.sv
/* privilege-mode checker top: retirement trace in, violation reports
   out over a credit channel to the debug sink */
`timescale 1ns/1ps

module umode_checker_top (
  input  logic                   clk_i,
  input  logic                   arst_n,
  input  umode_pkg::retire_rec_t retire,
  input  logic                   credit_return,
  output umode_pkg::report_t     report,
  output logic                   report_valid,
  output umode_pkg::seq_t        drop_count
);

  umode_pkg::decoded_t   dec;
  umode_pkg::rule_mask_t seq_mask;
  umode_pkg::rule_mask_t rec_mask;
  umode_pkg::seq_t       seq_num;
  logic                  stage2_valid;
  umode_pkg::priv_mode_t stage2_mode;

  retire_decoder u_decoder (
    .clk_i (clk_i),
    .arst_n(arst_n),
    .retire(retire),
    .dec   (dec)
  );

  mode_tracker u_tracker (
    .clk_i   (clk_i),
    .arst_n  (arst_n),
    .dec     (dec),
    .seq_mask(seq_mask),
    .seq_num (seq_num)
  );

  rule_checker u_rules (
    .clk_i       (clk_i),
    .arst_n      (arst_n),
    .dec         (dec),
    .rec_mask    (rec_mask),
    .stage2_valid(stage2_valid),
    .stage2_mode (stage2_mode)
  );

  report_ctrl u_ctrl (
    .clk_i        (clk_i),
    .arst_n       (arst_n),
    .stage2_valid (stage2_valid),
    .stage2_mode  (stage2_mode),
    .seq_mask     (seq_mask),
    .rec_mask     (rec_mask),
    .seq_num      (seq_num),
    .credit_return(credit_return),
    .report       (report),
    .report_valid (report_valid),
    .drop_count   (drop_count)
  );

endmodule

// File: tests/umode_checker_tb.sv
/* random-stimulus testbench for the privilege-mode checker; a model of
   the rules predicts each report, and a sink returns credits late */
`timescale 1ns/1ps
`include "umode_params.svh"

module umode_checker_tb;

  localparam int MIX_RECORDS    = 2000;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int CREDITS        = `UMODE_REPORT_CREDITS;

  logic clk_i = 1'b0;
  logic arst_n = 1'b0;
  logic credit_return = 1'b0;
  logic report_valid;
  umode_pkg::retire_rec_t retire = '0;
  umode_pkg::report_t     report;
  umode_pkg::seq_t        drop_count;

  // model state, updated as each record is driven
  logic                  m_first = 1'b1;
  logic                  m_prev_trap = 1'b0;
  logic                  m_pend = 1'b0;
  umode_pkg::priv_mode_t m_mpp = '0;
  umode_pkg::seq_t       m_seq = '0;
  umode_pkg::report_t    exp_q[$];
  int expected_total = 0;
  int received = 0;
  int skipped = 0;
  int outstanding = 0;
  int cycles = 0;
  logic hold = 1'b0;

  umode_checker_top UUT (
    .clk_i(clk_i), .arst_n(arst_n), .retire(retire), .credit_return(credit_return),
    .report(report), .report_valid(report_valid), .drop_count(drop_count)
  );

  always #5 clk_i = !clk_i;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_report(string name, umode_pkg::report_t expv, umode_pkg::report_t act);
    if (expv !== act) begin
      $display("Mismatch %s: expected seq=%0d mask=%h mode=%0d, actual seq=%0d mask=%h mode=%0d",
               name, expv.seq, expv.mask, expv.mode, act.seq, act.mask, act.mode);
      abort_run("report does not match the model");
    end
  endtask

  task automatic check_count(string name, umode_pkg::seq_t expv, umode_pkg::seq_t act);
    if (expv !== act) begin
      $display("Mismatch %s: expected %0d, actual %0d", name, expv, act);
      abort_run("count does not match the model");
    end
  endtask

  function automatic umode_pkg::rule_mask_t model_mask(umode_pkg::retire_rec_t r);
    umode_pkg::rule_mask_t m;
    umode_pkg::csr_word_t  post;
    logic u;
    logic ill;
    logic sys_csr;
    m = '0;
    u = (r.mode == 2'b00);
    ill = r.trap && (r.exc_cause == `UMODE_EXC_ILLEGAL);
    post = (r.mstatus_wdata & r.mstatus_wmask) | (r.mstatus_rdata & ~r.mstatus_wmask);
    sys_csr = (r.insn[6:0] == 7'b111_0011) && (r.insn[14:12] inside {1, 2, 3, 5, 6, 7});
    m[umode_pkg::RULE_MISA_BITS]   = !(r.misa_rdata[20] && !r.misa_rdata[18] &&
                                       !r.misa_rdata[13]);
    m[umode_pkg::RULE_MODE_LEGAL]  = !(r.mode == 2'b00 || r.mode == 2'b11);
    m[umode_pkg::RULE_RESET_MODE]  = m_first && (r.mode != 2'b11);
    m[umode_pkg::RULE_MSCRATCH_U]  = u && (r.mscratch_wmask != 0);
    m[umode_pkg::RULE_MPP_LEGAL]   = !(post[12:11] == 2'b00 || post[12:11] == 2'b11);
    m[umode_pkg::RULE_TRAP_TO_M]   = m_prev_trap && (r.mode != 2'b11);
    m[umode_pkg::RULE_DMODE_M]     = r.dbg_mode && (r.mode != 2'b11);
    m[umode_pkg::RULE_UMODE_MPRV]  = u && r.mstatus_rdata[17];
    m[umode_pkg::RULE_WFI_TW]      = u && (r.insn == 32'h1050_0073) &&
                                     (ill != r.mstatus_rdata[21]);
    m[umode_pkg::RULE_ECALL_U]     = u && (r.insn == 32'h0000_0073) &&
                                     !(r.trap && r.exc_cause == 6'd8);
    m[umode_pkg::RULE_MRET_TARGET] = m_pend && !r.intr && (r.mode != m_mpp);
    m[umode_pkg::RULE_CSR_PRIV]    = u && sys_csr && (r.insn[29:28] != 2'b00) && !ill;
    return m;
  endfunction

  // kind: 0 alu, 1 ecall, 2 wfi, 3 mret, 4 csr access
  function automatic umode_pkg::retire_rec_t build_rec(umode_pkg::priv_mode_t mode, int kind);
    umode_pkg::retire_rec_t r;
    logic u;
    r = '0;
    u = (mode == 2'b00);
    r.valid = 1'b1;
    r.mode = mode;
    r.dbg_mode = !u && ($urandom % 8 == 0);
    r.misa_rdata = ($urandom & ~32'h0004_2000) | 32'h0010_0000;
    r.mstatus_rdata = $urandom;
    r.mstatus_rdata[12:11] = ($urandom % 2 == 0) ? 2'b00 : 2'b11;
    if (u) r.mstatus_rdata[17] = 1'b0;
    r.mstatus_wmask = $urandom & ~32'h0000_1800;
    r.mstatus_wdata = $urandom;
    r.mscratch_wmask = u ? 32'h0 : $urandom;
    case (kind)
      1: begin
        r.insn = 32'h0000_0073;
        r.trap = 1'b1;
        r.exc_cause = u ? 6'd8 : 6'd11;
      end
      2: begin
        r.insn = 32'h1050_0073;
        r.trap = u && r.mstatus_rdata[21];
        r.exc_cause = r.trap ? 6'd2 : 6'd0;
      end
      3: begin
        r.insn = 32'h3020_0073;
        r.trap = u;
        r.exc_cause = u ? 6'd2 : 6'd0;
      end
      4: begin
        r.insn = {$urandom} & 32'hffff_8f80;
        r.insn[6:0] = 7'b111_0011;
        r.insn[14:12] = ($urandom % 2 == 0) ? 3'd1 : 3'(5 + $urandom % 3);
        r.trap = u && (r.insn[29:28] != 2'b00);
        r.exc_cause = r.trap ? 6'd2 : 6'd0;
      end
      default: begin
        r.insn = {$urandom} & 32'hffff_ff80 | 32'h13;
        r.trap = ($urandom % 8 == 0);
        r.exc_cause = r.trap ? 6'd5 : 6'd0;
      end
    endcase
    return r;
  endfunction

  function automatic umode_pkg::priv_mode_t legal_mode();
    if (m_first || m_prev_trap) return 2'b11;
    if (m_pend) return m_mpp;
    return ($urandom % 2 == 0) ? 2'b00 : 2'b11;
  endfunction

  function automatic umode_pkg::retire_rec_t fault_rec(int rule);
    umode_pkg::retire_rec_t r;
    case (rule)
      umode_pkg::RULE_MISA_BITS: begin
        r = build_rec(legal_mode(), 0);
        r.misa_rdata[20] = 0;
      end
      umode_pkg::RULE_MODE_LEGAL: begin
        r = build_rec(2'b11, 0);
        r.mode = 2'b01;
        r.dbg_mode = 1'b0;
      end
      umode_pkg::RULE_MSCRATCH_U: begin
        r = build_rec(2'b00, 0);
        r.mscratch_wmask = 32'h10;
      end
      umode_pkg::RULE_MPP_LEGAL: begin
        r = build_rec(legal_mode(), 0);
        r.mstatus_wmask[12:11] = 2'b11;
        r.mstatus_wdata[12:11] = 2'b01;
      end
      umode_pkg::RULE_DMODE_M: begin
        r = build_rec(2'b00, 0);
        r.dbg_mode = 1'b1;
      end
      umode_pkg::RULE_UMODE_MPRV: begin
        r = build_rec(2'b00, 0);
        r.mstatus_rdata[17] = 1;
      end
      umode_pkg::RULE_WFI_TW: begin
        r = build_rec(2'b00, 2);
        r.trap = !r.trap;
        r.exc_cause = r.trap ? 6'd2 : 6'd0;
      end
      umode_pkg::RULE_ECALL_U: begin
        r = build_rec(2'b00, 1);
        r.trap = 1'b0;
      end
      umode_pkg::RULE_CSR_PRIV: begin
        r = build_rec(2'b00, 4);
        r.insn[29:28] = 2'b11;
        r.trap = 1'b0;
      end
      default: begin
        // sequence rules: break the mode the model expects next
        r = build_rec(legal_mode(), 0);
        r.mode = (r.mode == 2'b11) ? 2'b00 : 2'b11;
      end
    endcase
    return r;
  endfunction

  task automatic drive_rec(umode_pkg::retire_rec_t r);
    umode_pkg::rule_mask_t m;
    umode_pkg::report_t    e;
    @(posedge clk_i);
    #1;
    retire = r;
    if (r.valid) begin
      m = model_mask(r);
      if (m != 0) begin
        e.seq = m_seq;
        e.mask = m;
        e.mode = r.mode;
        exp_q.push_back(e);
        expected_total++;
      end
      m_first = 1'b0;
      m_prev_trap = r.trap;
      m_pend = (r.insn == 32'h3020_0073) && !r.trap && !r.dbg_mode && (r.mode == 2'b11);
      m_mpp = r.mstatus_rdata[12:11];
      m_seq++;
    end
  endtask

  task automatic drive_gap(int n);
    umode_pkg::retire_rec_t r;
    repeat (n) begin
      r = build_rec(2'b00, $urandom % 5);
      r.valid = 1'b0;
      r.mode = 2'b10;
      drive_rec(r);
    end
  endtask

  // last record reaches the queue before reports and drops are counted
  task automatic drain();
    drive_gap(3);
    while (received + int'(drop_count) < expected_total) @(negedge clk_i);
  endtask

  // sink side: match reports in order, skipping only dropped entries
  always @(negedge clk_i) begin
    if (report_valid) begin
      received++;
      outstanding++;
      if (outstanding > CREDITS) abort_run("report sent without a credit");
      while (exp_q.size() > 1 && exp_q[0] != report && skipped < int'(drop_count)) begin
        void'(exp_q.pop_front());
        skipped++;
      end
      if (exp_q.size() == 0) abort_run("report received with none expected");
      check_report("report", exp_q.pop_front(), report);
    end
  end

  always @(posedge clk_i) begin
    #1;
    credit_return = 1'b0;
    if (!hold && outstanding > 0 && ($urandom % 4 == 0)) begin
      credit_return = 1'b1;
      outstanding--;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) abort_run("timeout waiting for the run to finish");
  end

  initial begin
    int single_rules[9];
    single_rules = '{0, 1, 3, 4, 6, 7, 8, 9, 11};
    void'($urandom(32'h3add_7e8b));
    repeat (4) begin
      @(posedge clk_i);
      #1;
      if (report_valid !== 1'b0) abort_run("report_valid high during reset");
      check_count("reset drop_count", '0, drop_count);
    end
    arst_n = 1'b1;
    // first retirement in user mode
    drive_rec(build_rec(2'b00, 0));
    drain();
    @(negedge clk_i);
    if (report_valid !== 1'b0) abort_run("report_valid stuck high");
    // legal records only
    expected_total = 0;
    received = 0;
    repeat (60) drive_rec(build_rec(legal_mode(), $urandom % 5));
    drain();
    check_count("legal reports", '0, umode_pkg::seq_t'(received));
    check_count("legal drops", '0, drop_count);
    foreach (single_rules[i]) begin
      // untrapped machine-mode wfi clears the sequence state
      drive_rec(build_rec(2'b11, 2));
      drive_rec(fault_rec(single_rules[i]));
      if (exp_q[$].mask != (12'd1 << single_rules[i])) abort_run("injected fault not isolated");
    end
    drain();
    // sequence rules across invalid cycles
    drive_rec(build_rec(2'b00, 1));
    drive_gap(3);
    drive_rec(build_rec(2'b00, 0));
    drive_rec(build_rec(2'b11, 3));
    drive_gap(2);
    drive_rec(fault_rec(umode_pkg::RULE_MRET_TARGET));
    drain();
    // credits withheld, queue fills and drops
    while (outstanding != 0) @(negedge clk_i);
    hold = 1'b1;
    repeat (10) drive_rec(fault_rec(umode_pkg::RULE_DMODE_M));
    drive_gap(20);
    hold = 1'b0;
    drain();
    check_count("drops", umode_pkg::seq_t'(expected_total - received), drop_count);
    repeat (MIX_RECORDS) begin
      if ($urandom % 8 == 0) drive_gap(1);
      if ($urandom % 10 == 0) drive_rec(fault_rec($urandom % 12));
      else drive_rec(build_rec(legal_mode(), $urandom % 5));
    end
    drain();
    check_count("final drops", umode_pkg::seq_t'(expected_total - received), drop_count);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/umode_pkg.sv
hdl/retire_decoder.sv
hdl/mode_tracker.sv
hdl/rule_checker.sv
hdl/report_fifo.sv
hdl/report_ctrl.sv
hdl/umode_checker_top.sv
tests/umode_checker_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module umode_checker_tb -o umode_tb
./obj_dir/umode_tb
